//--- hdl/lsu_pkg.sv
package lsu_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0]   xlen_t;
  typedef logic [XLEN-1:0]   addr_t;
  typedef logic [XLEN/8-1:0] strb_t;
  typedef logic [2:0]        funct3_t;

  // load codes, as in the RISC-V base ISA.
  localparam funct3_t FUNCT3_LB  = 3'b000;
  localparam funct3_t FUNCT3_LH  = 3'b001;
  localparam funct3_t FUNCT3_LW  = 3'b010;
  localparam funct3_t FUNCT3_LBU = 3'b100;
  localparam funct3_t FUNCT3_LHU = 3'b101;

  // store codes.
  localparam funct3_t FUNCT3_SB = 3'b000;
  localparam funct3_t FUNCT3_SH = 3'b001;
  localparam funct3_t FUNCT3_SW = 3'b010;

  // a load is a request with no byte enabled.
  typedef struct packed {
    addr_t addr;
    xlen_t wdata;
    strb_t wen;
  } cache_req_t;

  typedef struct packed {
    addr_t addr;
    xlen_t data;
  } cache_rsp_t;

  typedef struct packed {
    addr_t addr;
  } axi_ar_t;

  typedef struct packed {
    xlen_t data;
  } axi_r_t;

  typedef struct packed {
    addr_t addr;
  } axi_aw_t;

  typedef struct packed {
    xlen_t data;
    strb_t strb;
  } axi_w_t;

endpackage

//--- hdl/lsu.sv
`timescale 1ns/100ps

module lsu
  import lsu_pkg::*;
(
  input  logic       clk,
  input  logic       nrst,
  input  logic       i_valid,
  input  addr_t      i_addr,
  input  xlen_t      i_data,
  input  logic       i_we,
  input  funct3_t    i_funct,
  output logic       o_ready,
  output logic       o_valid,
  output xlen_t      o_rdata,
  output logic       o_req_valid,
  output cache_req_t o_req,
  input  logic       i_req_ready,
  input  logic       i_rsp_valid,
  input  cache_rsp_t i_rsp
);

  strb_t      wen;
  xlen_t      wdata;
  funct3_t    funct3_q;
  logic       accept;
  logic [1:0] byte_off;
  logic [7:0] load_byte;
  logic [15:0] load_half;

  assign o_ready     = i_req_ready;
  assign o_req_valid = i_valid;
  assign o_valid     = i_rsp_valid;
  assign accept      = i_valid && i_req_ready;

  // lane enables follow the size and the low address bits.
  // narrow store data is copied to every lane so the cache only needs the enables.
  always_comb begin
    wen   = '0;
    wdata = i_data;
    case (i_funct)
      FUNCT3_SB: begin
        wen   = strb_t'(1) << i_addr[1:0];
        wdata = {(XLEN/8){i_data[7:0]}};
      end
      FUNCT3_SH: begin
        wen   = i_addr[1] ? strb_t'(4'b1100) : strb_t'(4'b0011);
        wdata = {(XLEN/16){i_data[15:0]}};
      end
      FUNCT3_SW: begin
        wen = '1;
      end
      default: begin
        wen = '0;
      end
    endcase
    if (!i_we) begin
      wen = '0;
    end
  end

  assign o_req.addr  = i_addr;
  assign o_req.wdata = wdata;
  assign o_req.wen   = wen;

  // the size code is needed again when the word comes back.
  always_ff @(posedge clk) begin
    if (!nrst) begin
      funct3_q <= '0;
    end else if (accept) begin
      funct3_q <= i_funct;
    end
  end

  assign byte_off  = i_rsp.addr[1:0];
  assign load_byte = i_rsp.data[8*byte_off +: 8];
  assign load_half = byte_off[1] ? i_rsp.data[31:16] : i_rsp.data[15:0];

  always_comb begin
    case (funct3_q)
      FUNCT3_LB: begin
        o_rdata = {{(XLEN-8){load_byte[7]}}, load_byte};
      end
      FUNCT3_LBU: begin
        o_rdata = {{(XLEN-8){1'b0}}, load_byte};
      end
      FUNCT3_LH: begin
        o_rdata = {{(XLEN-16){load_half[15]}}, load_half};
      end
      FUNCT3_LHU: begin
        o_rdata = {{(XLEN-16){1'b0}}, load_half};
      end
      FUNCT3_LW: begin
        o_rdata = i_rsp.data;
      end
      default: begin
        o_rdata = i_rsp.data;
      end
    endcase
  end

endmodule

//--- hdl/dcache.sv
`timescale 1ns/100ps

module dcache
  import lsu_pkg::*;
#(
  parameter int INDEX_W = 4
) (
  input  logic       clk,
  input  logic       nrst,
  input  logic       i_req_valid,
  input  cache_req_t i_req,
  output logic       o_req_ready,
  output logic       o_rsp_valid,
  output cache_rsp_t o_rsp,
  output logic       o_ar_valid,
  output axi_ar_t    o_ar,
  input  logic       i_ar_ready,
  input  logic       i_r_valid,
  input  axi_r_t     i_r,
  output logic       o_aw_valid,
  output axi_aw_t    o_aw,
  input  logic       i_aw_ready,
  output logic       o_w_valid,
  output axi_w_t     o_w,
  input  logic       i_w_ready,
  input  logic       i_b_valid
);

  localparam int LINES = 2 ** INDEX_W;
  localparam int TAG_W = XLEN - INDEX_W - 2;

  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [TAG_W-1:0]   tag_t;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_READ_MISS,
    ST_WRITE,
    ST_RESPOND
  } state_t;

  state_t           state;
  state_t           state_nxt;
  tag_t             tag_mem [LINES];
  xlen_t            data_mem [LINES];
  logic [LINES-1:0] line_valid;
  cache_req_t       req_q;
  tag_t             tag_q;
  xlen_t            data_q;
  logic             valid_q;
  logic             ar_done;
  logic             aw_done;
  logic             w_done;
  index_t           req_index;
  index_t           idx_q;
  tag_t             tag_req;
  logic             accept;
  logic             is_store;
  logic             hit;
  logic             fill;
  logic             merge;
  xlen_t            merged;

  assign req_index = i_req.addr[INDEX_W+1:2];
  assign idx_q     = req_q.addr[INDEX_W+1:2];
  assign tag_req   = req_q.addr[XLEN-1:INDEX_W+2];

  assign o_req_ready = (state == ST_IDLE);
  assign accept      = i_req_valid && o_req_ready;
  assign is_store    = |req_q.wen;
  assign hit         = valid_q && (tag_q == tag_req);
  assign fill        = (state == ST_READ_MISS) && i_r_valid;
  assign merge       = (state == ST_LOOKUP) && is_store && hit;

  always_comb begin
    for (int i = 0; i < XLEN/8; i++) begin
      merged[8*i +: 8] = req_q.wen[i] ? req_q.wdata[8*i +: 8] : data_q[8*i +: 8];
    end
  end

  // lookup decides. Loads that hit answer at once, everything else goes to the bus.
  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (accept) begin
          state_nxt = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        if (is_store) begin
          state_nxt = ST_WRITE;
        end else if (hit) begin
          state_nxt = ST_IDLE;
        end else begin
          state_nxt = ST_READ_MISS;
        end
      end
      ST_READ_MISS: begin
        if (i_r_valid) begin
          state_nxt = ST_RESPOND;
        end
      end
      ST_WRITE: begin
        if (i_b_valid) begin
          state_nxt = ST_RESPOND;
        end
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  // bus requests go out already in the lookup cycle and stay up until taken.
  assign o_ar_valid = ((state == ST_LOOKUP) && !is_store && !hit) ||
                      ((state == ST_READ_MISS) && !ar_done);
  assign o_aw_valid = ((state == ST_LOOKUP) && is_store) ||
                      ((state == ST_WRITE) && !aw_done);
  assign o_w_valid  = ((state == ST_LOOKUP) && is_store) ||
                      ((state == ST_WRITE) && !w_done);

  assign o_rsp_valid = ((state == ST_LOOKUP) && !is_store && hit) || (state == ST_RESPOND);

  assign o_ar.addr  = {req_q.addr[XLEN-1:2], 2'b00};
  assign o_aw.addr  = {req_q.addr[XLEN-1:2], 2'b00};
  assign o_w.data   = req_q.wdata;
  assign o_w.strb   = req_q.wen;
  assign o_rsp.addr = req_q.addr;
  assign o_rsp.data = data_q;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      state      <= ST_IDLE;
      line_valid <= '0;
      ar_done    <= 1'b0;
      aw_done    <= 1'b0;
      w_done     <= 1'b0;
    end else begin
      state <= state_nxt;
      if (accept) begin
        ar_done <= 1'b0;
        aw_done <= 1'b0;
        w_done  <= 1'b0;
      end else begin
        ar_done <= ar_done || (o_ar_valid && i_ar_ready);
        aw_done <= aw_done || (o_aw_valid && i_aw_ready);
        w_done  <= w_done || (o_w_valid && i_w_ready);
      end
      if (fill) begin
        line_valid[idx_q] <= 1'b1;
      end
    end
  end

  // the line is read on acceptance and looked at in the next cycle.
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q   <= i_req;
      tag_q   <= tag_mem[req_index];
      data_q  <= data_mem[req_index];
      valid_q <= line_valid[req_index];
    end else if (fill) begin
      data_q <= i_r.data;
    end
  end

  always_ff @(posedge clk) begin
    if (fill) begin
      tag_mem[idx_q]  <= tag_req;
      data_mem[idx_q] <= i_r.data;
    end else if (merge) begin
      data_mem[idx_q] <= merged;
    end
  end

endmodule

//--- hdl/axi_mem.sv
`timescale 1ns/100ps

module axi_mem
  import lsu_pkg::*;
#(
  parameter int MEM_WORDS = 256
) (
  input  logic    clk,
  input  logic    nrst,
  input  logic    i_ar_valid,
  input  axi_ar_t i_ar,
  output logic    o_ar_ready,
  output logic    o_r_valid,
  output axi_r_t  o_r,
  input  logic    i_aw_valid,
  input  axi_aw_t i_aw,
  output logic    o_aw_ready,
  input  logic    i_w_valid,
  input  axi_w_t  i_w,
  output logic    o_w_ready,
  output logic    o_b_valid
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  typedef logic [IDX_W-1:0] word_idx_t;

  xlen_t     mem [MEM_WORDS];
  word_idx_t rd_idx;
  word_idx_t wr_idx;
  xlen_t     r_data_q;
  logic      r_valid_q;
  logic      b_valid_q;
  logic      rd_fire;
  logic      wr_fire;

  // MEM_WORDS is a power of two, so the low word bits give the address modulo the depth.
  assign rd_idx = i_ar.addr[IDX_W+1:2];
  assign wr_idx = i_aw.addr[IDX_W+1:2];

  assign o_ar_ready = !r_valid_q;
  assign rd_fire    = i_ar_valid && o_ar_ready;

  // address and data of a write are only taken together.
  assign o_aw_ready = i_w_valid && !b_valid_q;
  assign o_w_ready  = i_aw_valid && !b_valid_q;
  assign wr_fire    = i_aw_valid && i_w_valid && !b_valid_q;

  assign o_r_valid = r_valid_q;
  assign o_r.data  = r_data_q;
  assign o_b_valid = b_valid_q;

  // the master never stalls R or B, so each lasts exactly one cycle.
  always_ff @(posedge clk) begin
    if (!nrst) begin
      r_valid_q <= 1'b0;
      b_valid_q <= 1'b0;
    end else begin
      r_valid_q <= rd_fire;
      b_valid_q <= wr_fire;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      r_data_q <= mem[rd_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      for (int i = 0; i < XLEN/8; i++) begin
        if (i_w.strb[i]) begin
          mem[wr_idx][8*i +: 8] <= i_w.data[8*i +: 8];
        end
      end
    end
  end

endmodule

//--- hdl/lsu_top.sv
`timescale 1ns/100ps

module lsu_top
  import lsu_pkg::*;
#(
  parameter int INDEX_W   = 4,
  parameter int MEM_WORDS = 256
) (
  input  logic    clk,
  input  logic    nrst,
  input  logic    i_valid,
  input  addr_t   i_addr,
  input  xlen_t   i_data,
  input  logic    i_we,
  input  funct3_t i_funct,
  output logic    o_ready_req,
  output logic    o_valid,
  output xlen_t   o_rdata
);

  logic       req_valid;
  logic       req_ready;
  cache_req_t req;
  logic       rsp_valid;
  cache_rsp_t rsp;
  logic       ar_valid;
  logic       ar_ready;
  axi_ar_t    ar;
  logic       r_valid;
  axi_r_t     r;
  logic       aw_valid;
  logic       aw_ready;
  axi_aw_t    aw;
  logic       w_valid;
  logic       w_ready;
  axi_w_t     w;
  logic       b_valid;

  lsu u_lsu (
    .clk         (clk),
    .nrst        (nrst),
    .i_valid     (i_valid),
    .i_addr      (i_addr),
    .i_data      (i_data),
    .i_we        (i_we),
    .i_funct     (i_funct),
    .o_ready     (o_ready_req),
    .o_valid     (o_valid),
    .o_rdata     (o_rdata),
    .o_req_valid (req_valid),
    .o_req       (req),
    .i_req_ready (req_ready),
    .i_rsp_valid (rsp_valid),
    .i_rsp       (rsp)
  );

  dcache #(
    .INDEX_W (INDEX_W)
  ) u_dcache (
    .clk         (clk),
    .nrst        (nrst),
    .i_req_valid (req_valid),
    .i_req       (req),
    .o_req_ready (req_ready),
    .o_rsp_valid (rsp_valid),
    .o_rsp       (rsp),
    .o_ar_valid  (ar_valid),
    .o_ar        (ar),
    .i_ar_ready  (ar_ready),
    .i_r_valid   (r_valid),
    .i_r         (r),
    .o_aw_valid  (aw_valid),
    .o_aw        (aw),
    .i_aw_ready  (aw_ready),
    .o_w_valid   (w_valid),
    .o_w         (w),
    .i_w_ready   (w_ready),
    .i_b_valid   (b_valid)
  );

  axi_mem #(
    .MEM_WORDS (MEM_WORDS)
  ) u_mem (
    .clk        (clk),
    .nrst       (nrst),
    .i_ar_valid (ar_valid),
    .i_ar       (ar),
    .o_ar_ready (ar_ready),
    .o_r_valid  (r_valid),
    .o_r        (r),
    .i_aw_valid (aw_valid),
    .i_aw       (aw),
    .o_aw_ready (aw_ready),
    .i_w_valid  (w_valid),
    .i_w        (w),
    .o_w_ready  (w_ready),
    .o_b_valid  (b_valid)
  );

endmodule

//--- verif/tb_lsu_top.sv
`timescale 1ns/100ps

module tb_lsu_top
  import lsu_pkg::*;
;

  // each access takes at most about 6 cycles and the tests make about 330 of them.
  localparam int    MAX_CYCLES = 4000;
  localparam addr_t SUB_BASE   = 32'h0000_0180;
  localparam addr_t RAND_BASE  = 32'h0000_0200;

  logic    clk;
  logic    nrst;
  logic    i_valid;
  addr_t   i_addr;
  xlen_t   i_data;
  logic    i_we;
  funct3_t i_funct;
  logic    o_ready_req;
  logic    o_valid;
  xlen_t   o_rdata;

  logic [7:0] ref_mem [1024];
  int         errors;
  int         checks;
  int         cycle_count = 0;
  integer     seed = 32'he1cd;

  lsu_top #(
    .INDEX_W   (4),
    .MEM_WORDS (256)
  ) uut (
    .clk         (clk),
    .nrst        (nrst),
    .i_valid     (i_valid),
    .i_addr      (i_addr),
    .i_data      (i_data),
    .i_we        (i_we),
    .i_funct     (i_funct),
    .o_ready_req (o_ready_req),
    .o_valid     (o_valid),
    .o_rdata     (o_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("tests failed");
      $finish;
    end
  end

  task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_cycles(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // the two low funct3 bits give the access size for loads and stores alike.
  function automatic int access_bytes(input funct3_t f);
    if (f[1:0] == 2'b00) begin
      return 1;
    end else if (f[1:0] == 2'b01) begin
      return 2;
    end
    return 4;
  endfunction

  task automatic model_store(input addr_t addr, input xlen_t data, input funct3_t f);
    int nbytes;
    int base;
    nbytes = access_bytes(f);
    base   = int'(addr[9:0]) & ~(nbytes - 1);
    for (int i = 0; i < nbytes; i++) begin
      ref_mem[base + i] = data[8*i +: 8];
    end
  endtask

  function automatic xlen_t model_load(input addr_t addr, input funct3_t f);
    int    nbytes;
    int    base;
    xlen_t val;
    nbytes = access_bytes(f);
    base   = int'(addr[9:0]) & ~(nbytes - 1);
    val    = '0;
    for (int i = 0; i < nbytes; i++) begin
      val[8*i +: 8] = ref_mem[base + i];
    end
    case (f)
      FUNCT3_LB: val = {{24{val[7]}}, val[7:0]};
      FUNCT3_LH: val = {{16{val[15]}}, val[15:0]};
      default: ;
    endcase
    return val;
  endfunction

  // called 0.5 ns after a rising edge; returns at the same point of the o_valid cycle.
  task automatic do_access(input addr_t addr, input xlen_t data, input logic we,
                           input funct3_t f, output xlen_t rdata, output int cycles);
    i_addr  = addr;
    i_data  = data;
    i_we    = we;
    i_funct = f;
    i_valid = 1'b1;
    while (!o_ready_req) begin
      @(posedge clk);
      #0.5;
    end
    @(posedge clk);
    #0.5;
    i_valid = 1'b0;
    cycles  = 1;
    while (!o_valid) begin
      @(posedge clk);
      #0.5;
      cycles++;
    end
    rdata = o_rdata;
    if (we) begin
      model_store(addr, data, f);
    end
  endtask

  task automatic store_op(input addr_t addr, input xlen_t data, input funct3_t f);
    xlen_t rdata;
    int    cycles;
    do_access(addr, data, 1'b1, f, rdata, cycles);
  endtask

  task automatic load_and_check(input addr_t addr, input funct3_t f, output int cycles);
    xlen_t rdata;
    do_access(addr, '0, 1'b0, f, rdata, cycles);
    check_word($sformatf("o_rdata[%h f3=%0d]", addr, f), rdata, model_load(addr, f));
  endtask

  task automatic check_all_sizes(input addr_t a);
    int cycles;
    load_and_check(a, FUNCT3_LB, cycles);
    load_and_check(a, FUNCT3_LBU, cycles);
    load_and_check(a & ~addr_t'(1), FUNCT3_LH, cycles);
    load_and_check(a & ~addr_t'(1), FUNCT3_LHU, cycles);
    load_and_check(a & ~addr_t'(3), FUNCT3_LW, cycles);
  endtask

  task automatic test_reset();
    check_flag("o_valid", o_valid, 1'b0);
    check_flag("o_ready_req", o_ready_req, 1'b1);
  endtask

  task automatic test_word_round_trip();
    int cycles;
    for (int i = 0; i < 8; i++) begin
      store_op(addr_t'(i * 12), xlen_t'(32'h1357_9bdf + i * 32'h1111_1111), FUNCT3_SW);
    end
    for (int i = 0; i < 8; i++) begin
      load_and_check(addr_t'(i * 12), FUNCT3_LW, cycles);
    end
  endtask

  // upper data bits are junk so that only the addressed lanes may change.
  task automatic test_subword();
    addr_t a;
    store_op(SUB_BASE, 32'h0102_0304, FUNCT3_SW);
    for (int k = 0; k < 4; k++) begin
      a = SUB_BASE + addr_t'(k);
      store_op(a, xlen_t'(32'hdead_be00) | xlen_t'(k * 37 + 120), FUNCT3_SB);
      check_all_sizes(a);
    end
    store_op(SUB_BASE + 4, 32'h5566_7788, FUNCT3_SW);
    store_op(SUB_BASE + 4, 32'hffff_8a31, FUNCT3_SH);
    check_all_sizes(SUB_BASE + 5);
    store_op(SUB_BASE + 6, 32'h0000_7bcd, FUNCT3_SH);
    check_all_sizes(SUB_BASE + 7);
  endtask

  task automatic test_hit_latency();
    int cycles;
    store_op(32'h0000_00c8, 32'h8765_4321, FUNCT3_SW);
    load_and_check(32'h0000_00c8, FUNCT3_LW, cycles);
    load_and_check(32'h0000_00c8, FUNCT3_LW, cycles);
    check_cycles("hit latency LW", cycles, 1);
    load_and_check(32'h0000_00cb, FUNCT3_LB, cycles);
    check_cycles("hit latency LB", cycles, 1);
  endtask

  // A and B share cache index 0 with different tags.
  task automatic test_conflict();
    int cycles;
    store_op(32'h0000_0100, 32'haaaa_0001, FUNCT3_SW);
    load_and_check(32'h0000_0100, FUNCT3_LW, cycles);
    store_op(32'h0000_0140, 32'hbbbb_0002, FUNCT3_SW);
    load_and_check(32'h0000_0140, FUNCT3_LW, cycles);
    store_op(32'h0000_0100, 32'haaaa_0003, FUNCT3_SW);
    load_and_check(32'h0000_0100, FUNCT3_LW, cycles);
    load_and_check(32'h0000_0140, FUNCT3_LW, cycles);
  endtask

  task automatic test_random();
    int      word;
    int      off;
    int      sel;
    int      cycles;
    xlen_t   d;
    funct3_t f;
    addr_t   a;
    for (int i = 0; i < 64; i++) begin
      store_op(RAND_BASE + addr_t'(i * 4), xlen_t'($random(seed)), FUNCT3_SW);
    end
    for (int n = 0; n < 200; n++) begin
      word = $unsigned($random(seed)) % 64;
      off  = $unsigned($random(seed)) % 4;
      sel  = $unsigned($random(seed)) % 8;
      d    = $random(seed);
      case (sel)
        0: f = FUNCT3_SB;
        1: f = FUNCT3_SH;
        2: f = FUNCT3_SW;
        3: f = FUNCT3_LB;
        4: f = FUNCT3_LH;
        5: f = FUNCT3_LW;
        6: f = FUNCT3_LBU;
        default: f = FUNCT3_LHU;
      endcase
      off = off & ~(access_bytes(f) - 1);
      a   = RAND_BASE + addr_t'(word * 4 + off);
      if (sel < 3) begin
        store_op(a, d, f);
      end else begin
        load_and_check(a, f, cycles);
      end
    end
  endtask

  initial begin
    nrst    = 1'b0;
    i_valid = 1'b0;
    i_addr  = '0;
    i_data  = '0;
    i_we    = 1'b0;
    i_funct = '0;
    errors  = 0;
    checks  = 0;
    repeat (10) @(posedge clk);
    #0.5;
    nrst = 1'b1;
    test_reset();
    test_word_round_trip();
    test_subword();
    test_hit_latency();
    test_conflict();
    test_random();
    $display("errors: %0d in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- compile.f
hdl/lsu_pkg.sv
hdl/lsu.sv
hdl/dcache.sv
hdl/axi_mem.sv
hdl/lsu_top.sv
verif/tb_lsu_top.sv

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it; exit status follows the result.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f compile.f --top-module tb_lsu_top -o sim_tb_lsu_top \
  && ./obj_dir/sim_tb_lsu_top | tee /dev/stderr | grep -qx "all tests passed" \
  && echo "RESULT: PASS" \
  || { echo "RESULT: FAIL"; exit 1; }
